/* src/gfx_reg_pkg.sv */
////////////////////////////////////////
// byte addresses of the kept registers on a word grid
// unlisted registers reset to zero
////////////////////////////////////////
`default_nettype none

package gfx_reg_pkg;

  localparam int GFX_ADDR_W = 8;

  // word aligned byte addresses
  localparam logic [GFX_ADDR_W-1:0] GFX_CONTROL       = 8'h00;
  localparam logic [GFX_ADDR_W-1:0] GFX_STATUS        = 8'h04;
  localparam logic [GFX_ADDR_W-1:0] GFX_TARGET_BASE   = 8'h08;
  localparam logic [GFX_ADDR_W-1:0] GFX_TARGET_SIZE_X = 8'h0C;
  localparam logic [GFX_ADDR_W-1:0] GFX_TARGET_SIZE_Y = 8'h10;
  localparam logic [GFX_ADDR_W-1:0] GFX_CLIP_X0       = 8'h14;
  localparam logic [GFX_ADDR_W-1:0] GFX_CLIP_Y0       = 8'h18;
  localparam logic [GFX_ADDR_W-1:0] GFX_CLIP_X1       = 8'h1C;
  localparam logic [GFX_ADDR_W-1:0] GFX_CLIP_Y1       = 8'h20;
  localparam logic [GFX_ADDR_W-1:0] GFX_DEST_X        = 8'h24;
  localparam logic [GFX_ADDR_W-1:0] GFX_DEST_Y        = 8'h28;
  localparam logic [GFX_ADDR_W-1:0] GFX_COLOR0        = 8'h2C;
  localparam logic [GFX_ADDR_W-1:0] GFX_ALPHA         = 8'h30;

  // control register fields
  localparam int GFX_CTRL_DEPTH_LSB = 0;
  localparam int GFX_CTRL_DEPTH_W   = 2;
  localparam int GFX_CTRL_RECT      = 4;
  localparam int GFX_CTRL_LINE      = 5;
  localparam int GFX_CTRL_CLIP      = 8;
  localparam int GFX_CTRL_BLEND     = 9;

  // status register fields
  localparam int GFX_STAT_BUSY      = 0;
  localparam int GFX_STAT_COUNT_LSB = 16;

  // target base is 8 byte aligned
  localparam int GFX_BASE_LSB = 3;

  localparam logic [31:0] GFX_ALPHA_RESET = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

/* src/gfx_types_pkg.sv */
////////////////////////////////////////
// queue depth must stay a power of two
////////////////////////////////////////
`default_nettype none

package gfx_types_pkg;
  import gfx_reg_pkg::*;

  localparam int REG_W          = 32;
  localparam int POINT_W        = 16;
  localparam int COLOR_W        = 32;
  localparam int ALPHA_W        = 8;
  localparam int CMD_FIFO_DEPTH = 16;
  localparam int CMD_FIFO_PTR_W = $clog2(CMD_FIFO_DEPTH);
  localparam int FIFO_COUNT_W   = CMD_FIFO_PTR_W + 1;

  typedef logic [REG_W-1:0]        reg_word_t;
  typedef logic [GFX_ADDR_W-1:0]   reg_addr_t;
  typedef logic [POINT_W-1:0]      point_t;
  typedef logic [COLOR_W-1:0]      color_t;
  typedef logic [FIFO_COUNT_W-1:0] fifo_count_t;
  typedef logic [REG_W/8-1:0]      axi_strb_t;
  typedef logic [1:0]              axi_resp_t;

  localparam axi_resp_t AXI_RESP_OKAY   = 2'b00;
  localparam axi_resp_t AXI_RESP_SLVERR = 2'b10;
  localparam axi_strb_t AXI_STRB_FULL   = '1;

  // one queued register write
  typedef struct packed {
    reg_addr_t addr;
    reg_word_t data;
  } cmd_entry_t;

  typedef struct packed {
    logic [REG_W-GFX_BASE_LSB-1:0] target_base;
    point_t                        size_x;
    point_t                        size_y;
    point_t                        clip_x0;
    point_t                        clip_y0;
    point_t                        clip_x1;
    point_t                        clip_y1;
    point_t                        dest_x;
    point_t                        dest_y;
    color_t                        color0;
    logic [ALPHA_W-1:0]            global_alpha;
    logic [GFX_CTRL_DEPTH_W-1:0]   color_depth;
    logic                          clip_enable;
    logic                          blend_enable;
  } draw_params_t;

  typedef enum logic {
    EXEC_IDLE,
    EXEC_BUSY
  } exec_state_e;

endpackage

`default_nettype wire

/* src/gfx_axil_slave.sv */
////////////////////////////////////////
// one outstanding write and one outstanding read
// partial strobes get SLVERR and are dropped
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module gfx_axil_slave
  import gfx_reg_pkg::*;
  import gfx_types_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_i,
  input  wire reg_addr_t  s_awaddr_i,
  input  wire logic       s_awvalid_i,
  output logic            s_awready_o,
  input  wire reg_word_t  s_wdata_i,
  input  wire axi_strb_t  s_wstrb_i,
  input  wire logic       s_wvalid_i,
  output logic            s_wready_o,
  output axi_resp_t       s_bresp_o,
  output logic            s_bvalid_o,
  input  wire logic       s_bready_i,
  input  wire reg_addr_t  s_araddr_i,
  input  wire logic       s_arvalid_i,
  output logic            s_arready_o,
  output reg_word_t       s_rdata_o,
  output axi_resp_t       s_rresp_o,
  output logic            s_rvalid_o,
  input  wire logic       s_rready_i,
  output logic            push_o,
  output cmd_entry_t      push_entry_o,
  input  wire logic       fifo_full_i,
  output reg_addr_t       rd_addr_o,
  input  wire reg_word_t  rd_data_i
);

  logic      wr_accept;
  logic      wr_full_word;
  logic      rd_accept;
  logic      bvalid_q;
  axi_resp_t bresp_q;
  logic      rvalid_q;
  logic      rvalid_d;
  logic      arready_q;
  reg_word_t rdata_q;

  function automatic reg_addr_t word_addr(input reg_addr_t addr);
    return {addr[GFX_ADDR_W-1:2], 2'b00};
  endfunction

  // address and data must arrive together
  assign wr_accept    = s_awvalid_i & s_wvalid_i & ~bvalid_q & ~fifo_full_i;
  assign wr_full_word = (s_wstrb_i == AXI_STRB_FULL);
  assign s_awready_o  = wr_accept;
  assign s_wready_o   = wr_accept;

  assign push_o            = wr_accept & wr_full_word;
  assign push_entry_o.addr = word_addr(s_awaddr_i);
  assign push_entry_o.data = s_wdata_i;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      bvalid_q <= 1'b0;
    end
    else if (wr_accept)
    begin
      bvalid_q <= 1'b1;
    end
    else if (s_bready_i)
    begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_accept)
    begin
      bresp_q <= wr_full_word ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
    end
  end

  assign s_bvalid_o = bvalid_q;
  assign s_bresp_o  = bresp_q;

  // read side
  assign rd_accept = s_arvalid_i & arready_q;
  assign rd_addr_o = word_addr(s_araddr_i);

  always_comb
  begin
    rvalid_d = rvalid_q;
    if (rd_accept)
    begin
      rvalid_d = 1'b1;
    end
    else if (s_rready_i)
    begin
      rvalid_d = 1'b0;
    end
  end

  // arready follows the next rvalid so it is low out of reset
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      rvalid_q  <= 1'b0;
      arready_q <= 1'b0;
    end
    else
    begin
      rvalid_q  <= rvalid_d;
      arready_q <= ~rvalid_d;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rd_accept)
    begin
      rdata_q <= rd_data_i;
    end
  end

  assign s_arready_o = arready_q;
  assign s_rvalid_o  = rvalid_q;
  assign s_rdata_o   = rdata_q;
  // unmapped reads return zero and still answer OKAY
  assign s_rresp_o   = AXI_RESP_OKAY;

endmodule

`default_nettype wire

/* src/gfx_cmd_fifo.sv */
////////////////////////////////////////
// push while full and pop while empty are ignored
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module gfx_cmd_fifo
  import gfx_types_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  input  wire logic        push_i,
  input  wire cmd_entry_t  push_entry_i,
  output logic             full_o,
  input  wire logic        pop_i,
  output logic             valid_o,
  output cmd_entry_t       head_o,
  output fifo_count_t      count_o
);

  cmd_entry_t                mem [CMD_FIFO_DEPTH];
  logic [CMD_FIFO_PTR_W-1:0] wr_ptr_q;
  logic [CMD_FIFO_PTR_W-1:0] rd_ptr_q;
  fifo_count_t               count_q;
  logic                      do_push;
  logic                      do_pop;

  assign full_o  = (count_q == fifo_count_t'(CMD_FIFO_DEPTH));
  assign valid_o = (count_q != '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & valid_o;

  // head is visible without a read cycle
  assign head_o  = mem[rd_ptr_q];
  assign count_o = count_q;

  always_ff @(posedge clk_i)
  begin
    if (do_push)
    begin
      mem[wr_ptr_q] <= push_entry_i;
    end
  end

  // pointers wrap on their own width
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop)
      begin
        count_q <= count_q + 1'b1;
      end
      else if (do_pop && !do_push)
      begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/gfx_cmd_executor.sv */
////////////////////////////////////////
// writes to status or unmapped addresses are dropped
// busy also covers a trigger not yet launched
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module gfx_cmd_executor
  import gfx_reg_pkg::*;
  import gfx_types_pkg::*;
(
  input  wire logic         clk_i,
  input  wire logic         rst_i,
  input  wire logic         fifo_valid_i,
  input  wire cmd_entry_t   fifo_head_i,
  input  wire fifo_count_t  fifo_count_i,
  output logic              pop_o,
  input  wire reg_addr_t    rd_addr_i,
  output reg_word_t         rd_data_o,
  output draw_params_t      draw_params_o,
  output logic              rect_start_o,
  output logic              line_start_o,
  input  wire logic         draw_done_i
);

  exec_state_e state_q;
  reg_word_t   control_q;
  reg_word_t   target_base_q;
  reg_word_t   size_x_q;
  reg_word_t   size_y_q;
  reg_word_t   clip_x0_q;
  reg_word_t   clip_y0_q;
  reg_word_t   clip_x1_q;
  reg_word_t   clip_y1_q;
  reg_word_t   dest_x_q;
  reg_word_t   dest_y_q;
  reg_word_t   color0_q;
  reg_word_t   alpha_q;
  reg_word_t   status_w;
  logic        trig_pending;
  logic        launch;

  assign trig_pending = control_q[GFX_CTRL_RECT] | control_q[GFX_CTRL_LINE];
  // queued writes wait while a draw is pending or running
  assign pop_o        = fifo_valid_i & (state_q == EXEC_IDLE) & ~trig_pending;
  assign launch       = (state_q == EXEC_IDLE) & trig_pending;
  assign rect_start_o = launch & control_q[GFX_CTRL_RECT];
  assign line_start_o = launch & control_q[GFX_CTRL_LINE];

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      control_q     <= '0;
      target_base_q <= '0;
      size_x_q      <= '0;
      size_y_q      <= '0;
      clip_x0_q     <= '0;
      clip_y0_q     <= '0;
      clip_x1_q     <= '0;
      clip_y1_q     <= '0;
      dest_x_q      <= '0;
      dest_y_q      <= '0;
      color0_q      <= '0;
      alpha_q       <= GFX_ALPHA_RESET;
    end
    else if (pop_o)
    begin
      case (fifo_head_i.addr)
        GFX_CONTROL:       control_q     <= fifo_head_i.data;
        GFX_TARGET_BASE:   target_base_q <= fifo_head_i.data;
        GFX_TARGET_SIZE_X: size_x_q      <= fifo_head_i.data;
        GFX_TARGET_SIZE_Y: size_y_q      <= fifo_head_i.data;
        GFX_CLIP_X0:       clip_x0_q     <= fifo_head_i.data;
        GFX_CLIP_Y0:       clip_y0_q     <= fifo_head_i.data;
        GFX_CLIP_X1:       clip_x1_q     <= fifo_head_i.data;
        GFX_CLIP_Y1:       clip_y1_q     <= fifo_head_i.data;
        GFX_DEST_X:        dest_x_q      <= fifo_head_i.data;
        GFX_DEST_Y:        dest_y_q      <= fifo_head_i.data;
        GFX_COLOR0:        color0_q      <= fifo_head_i.data;
        GFX_ALPHA:         alpha_q       <= fifo_head_i.data;
        default: ;
      endcase
    end
    else if (launch)
    begin
      // trigger bits are one shot
      control_q[GFX_CTRL_RECT] <= 1'b0;
      control_q[GFX_CTRL_LINE] <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= EXEC_IDLE;
    end
    else
    begin
      case (state_q)
        EXEC_IDLE:
        begin
          if (launch)
          begin
            state_q <= EXEC_BUSY;
          end
        end
        EXEC_BUSY:
        begin
          if (draw_done_i)
          begin
            state_q <= EXEC_IDLE;
          end
        end
        default:
        begin
          state_q <= EXEC_IDLE;
        end
      endcase
    end
  end

  assign draw_params_o.target_base  = target_base_q[REG_W-1:GFX_BASE_LSB];
  assign draw_params_o.size_x       = size_x_q[POINT_W-1:0];
  assign draw_params_o.size_y       = size_y_q[POINT_W-1:0];
  assign draw_params_o.clip_x0      = clip_x0_q[POINT_W-1:0];
  assign draw_params_o.clip_y0      = clip_y0_q[POINT_W-1:0];
  assign draw_params_o.clip_x1      = clip_x1_q[POINT_W-1:0];
  assign draw_params_o.clip_y1      = clip_y1_q[POINT_W-1:0];
  assign draw_params_o.dest_x       = dest_x_q[POINT_W-1:0];
  assign draw_params_o.dest_y       = dest_y_q[POINT_W-1:0];
  assign draw_params_o.color0       = color0_q;
  assign draw_params_o.global_alpha = alpha_q[ALPHA_W-1:0];
  assign draw_params_o.color_depth  = control_q[GFX_CTRL_DEPTH_LSB +: GFX_CTRL_DEPTH_W];
  assign draw_params_o.clip_enable  = control_q[GFX_CTRL_CLIP];
  assign draw_params_o.blend_enable = control_q[GFX_CTRL_BLEND];

  always_comb
  begin
    status_w = '0;
    status_w[GFX_STAT_BUSY] = (state_q == EXEC_BUSY) | trig_pending;
    status_w[GFX_STAT_COUNT_LSB +: FIFO_COUNT_W] = fifo_count_i;
  end

  // applied values only
  always_comb
  begin
    case (rd_addr_i)
      GFX_CONTROL:       rd_data_o = control_q;
      GFX_STATUS:        rd_data_o = status_w;
      GFX_TARGET_BASE:   rd_data_o = target_base_q;
      GFX_TARGET_SIZE_X: rd_data_o = size_x_q;
      GFX_TARGET_SIZE_Y: rd_data_o = size_y_q;
      GFX_CLIP_X0:       rd_data_o = clip_x0_q;
      GFX_CLIP_Y0:       rd_data_o = clip_y0_q;
      GFX_CLIP_X1:       rd_data_o = clip_x1_q;
      GFX_CLIP_Y1:       rd_data_o = clip_y1_q;
      GFX_DEST_X:        rd_data_o = dest_x_q;
      GFX_DEST_Y:        rd_data_o = dest_y_q;
      GFX_COLOR0:        rd_data_o = color0_q;
      GFX_ALPHA:         rd_data_o = alpha_q;
      default:           rd_data_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* src/gfx_ctrl_top.sv */
////////////////////////////////////////
// AXI4-Lite register front end of the 2D engine
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module gfx_ctrl_top
  import gfx_types_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_i,
  input  wire reg_addr_t  s_awaddr_i,
  input  wire logic       s_awvalid_i,
  output logic            s_awready_o,
  input  wire reg_word_t  s_wdata_i,
  input  wire axi_strb_t  s_wstrb_i,
  input  wire logic       s_wvalid_i,
  output logic            s_wready_o,
  output axi_resp_t       s_bresp_o,
  output logic            s_bvalid_o,
  input  wire logic       s_bready_i,
  input  wire reg_addr_t  s_araddr_i,
  input  wire logic       s_arvalid_i,
  output logic            s_arready_o,
  output reg_word_t       s_rdata_o,
  output axi_resp_t       s_rresp_o,
  output logic            s_rvalid_o,
  input  wire logic       s_rready_i,
  output draw_params_t    draw_params_o,
  output logic            rect_start_o,
  output logic            line_start_o,
  input  wire logic       draw_done_i
);

  logic        push;
  cmd_entry_t  push_entry;
  logic        fifo_full;
  logic        pop;
  logic        fifo_valid;
  cmd_entry_t  fifo_head;
  fifo_count_t fifo_count;
  reg_addr_t   rd_addr;
  reg_word_t   rd_data;

  gfx_axil_slave axil_slave_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .s_awaddr_i   (s_awaddr_i),
    .s_awvalid_i  (s_awvalid_i),
    .s_awready_o  (s_awready_o),
    .s_wdata_i    (s_wdata_i),
    .s_wstrb_i    (s_wstrb_i),
    .s_wvalid_i   (s_wvalid_i),
    .s_wready_o   (s_wready_o),
    .s_bresp_o    (s_bresp_o),
    .s_bvalid_o   (s_bvalid_o),
    .s_bready_i   (s_bready_i),
    .s_araddr_i   (s_araddr_i),
    .s_arvalid_i  (s_arvalid_i),
    .s_arready_o  (s_arready_o),
    .s_rdata_o    (s_rdata_o),
    .s_rresp_o    (s_rresp_o),
    .s_rvalid_o   (s_rvalid_o),
    .s_rready_i   (s_rready_i),
    .push_o       (push),
    .push_entry_o (push_entry),
    .fifo_full_i  (fifo_full),
    .rd_addr_o    (rd_addr),
    .rd_data_i    (rd_data)
  );

  gfx_cmd_fifo cmd_fifo_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .push_i       (push),
    .push_entry_i (push_entry),
    .full_o       (fifo_full),
    .pop_i        (pop),
    .valid_o      (fifo_valid),
    .head_o       (fifo_head),
    .count_o      (fifo_count)
  );

  gfx_cmd_executor cmd_executor_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fifo_valid_i  (fifo_valid),
    .fifo_head_i   (fifo_head),
    .fifo_count_i  (fifo_count),
    .pop_o         (pop),
    .rd_addr_i     (rd_addr),
    .rd_data_o     (rd_data),
    .draw_params_o (draw_params_o),
    .rect_start_o  (rect_start_o),
    .line_start_o  (line_start_o),
    .draw_done_i   (draw_done_i)
  );

endmodule

`default_nettype wire

/* sim/gfx_ctrl_checker.sv */
////////////////////////////////////////
// expected values come in on ports
// one transaction per channel in flight
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module gfx_ctrl_checker
  import gfx_types_pkg::*;
(
  input  wire logic          clk_i,
  input  wire logic          rst_i,
  input  wire logic          s_awready_i,
  input  wire logic          s_wready_i,
  input  wire axi_resp_t     s_bresp_i,
  input  wire logic          s_bvalid_i,
  input  wire logic          s_bready_i,
  input  wire logic          s_arready_i,
  input  wire reg_word_t     s_rdata_i,
  input  wire axi_resp_t     s_rresp_i,
  input  wire logic          s_rvalid_i,
  input  wire logic          s_rready_i,
  input  wire draw_params_t  draw_params_i,
  input  wire logic          rect_start_i,
  input  wire logic          line_start_i,
  input  wire logic          draw_done_i,
  input  wire axi_resp_t     exp_bresp_i,
  input  wire reg_word_t     exp_rdata_i,
  input  wire reg_word_t     exp_rmask_i,
  input  wire draw_params_t  exp_params_i,
  input  wire logic          exp_rect_i,
  input  wire logic          exp_line_i,
  output int                 err_count_o,
  output int                 b_count_o,
  output int                 r_count_o
);

  int errors  = 0;
  int b_count = 0;
  int r_count = 0;

  assign err_count_o = errors;
  assign b_count_o   = b_count;
  assign r_count_o   = r_count;

  always @(posedge clk_i)
  begin
    if (rst_i)
    begin
      if ({s_awready_i, s_wready_i, s_bvalid_i, s_arready_i, s_rvalid_i,
           rect_start_i, line_start_i} != '0)
      begin
        $display("[ERROR] ready, valid and start outputs in reset: got %h, expected %h",
                 {s_awready_i, s_wready_i, s_bvalid_i, s_arready_i, s_rvalid_i,
                  rect_start_i, line_start_i}, 7'h00);
        errors = errors + 1;
      end
    end
    else
    begin
      // address and data channels are taken in the same cycle
      if (s_wready_i != s_awready_i)
      begin
        $display("[ERROR] s_wready_o: got %h, expected %h", s_wready_i, s_awready_i);
        errors = errors + 1;
      end
      if (s_bvalid_i && s_bready_i)
      begin
        b_count = b_count + 1;
        if (s_bresp_i != exp_bresp_i)
        begin
          $display("[ERROR] s_bresp_o: got %h, expected %h", s_bresp_i, exp_bresp_i);
          errors = errors + 1;
        end
      end
      if (s_rvalid_i && s_rready_i)
      begin
        r_count = r_count + 1;
        if (((s_rdata_i ^ exp_rdata_i) & exp_rmask_i) != '0)
        begin
          $display("[ERROR] s_rdata_o: got %h, expected %h (mask %h)",
                   s_rdata_i, exp_rdata_i, exp_rmask_i);
          errors = errors + 1;
        end
        if (s_rresp_i != AXI_RESP_OKAY)
        begin
          $display("[ERROR] s_rresp_o: got %h, expected %h", s_rresp_i, AXI_RESP_OKAY);
          errors = errors + 1;
        end
      end
      // start pulses only where the testbench asked for one
      if (rect_start_i || line_start_i)
      begin
        if ({rect_start_i, line_start_i} != {exp_rect_i, exp_line_i})
        begin
          $display("[ERROR] rect_start_o/line_start_o: got %h, expected %h",
                   {rect_start_i, line_start_i}, {exp_rect_i, exp_line_i});
          errors = errors + 1;
        end
        if (draw_params_i != exp_params_i)
        begin
          $display("[ERROR] draw_params_o at start: got %h, expected %h",
                   draw_params_i, exp_params_i);
          errors = errors + 1;
        end
      end
      // queued writes must not leak in while the engine runs
      if (draw_done_i && (draw_params_i != exp_params_i))
      begin
        $display("[ERROR] draw_params_o at draw_done_i: got %h, expected %h",
                 draw_params_i, exp_params_i);
        errors = errors + 1;
      end
    end
  end

endmodule

`default_nettype wire

/* sim/tb_gfx_ctrl.sv */
////////////////////////////////////////
// one transaction per channel at a time
// B/R stalls stay shorter than any draw
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_gfx_ctrl
  import gfx_reg_pkg::*;
  import gfx_types_pkg::*;
();

  // a few hundred transactions of under 15 cycles each, with margin
  localparam int CYCLE_LIMIT = 6000;
  localparam reg_word_t TRIG_MASK = (32'd1 << GFX_CTRL_RECT) | (32'd1 << GFX_CTRL_LINE);

  logic         clk_i;
  logic         rst_i;
  reg_addr_t    s_awaddr;
  logic         s_awvalid;
  logic         s_awready;
  reg_word_t    s_wdata;
  axi_strb_t    s_wstrb;
  logic         s_wvalid;
  logic         s_wready;
  axi_resp_t    s_bresp;
  logic         s_bvalid;
  logic         s_bready;
  reg_addr_t    s_araddr;
  logic         s_arvalid;
  logic         s_arready;
  reg_word_t    s_rdata;
  axi_resp_t    s_rresp;
  logic         s_rvalid;
  logic         s_rready;
  draw_params_t draw_params;
  logic         rect_start;
  logic         line_start;
  logic         draw_done;

  axi_resp_t    exp_bresp;
  reg_word_t    exp_rdata;
  reg_word_t    exp_rmask;
  draw_params_t exp_params;
  logic         exp_rect;
  logic         exp_line;

  reg_word_t    shadow [64];
  logic         use_stalls;
  int           wr_requests = 0;
  int           rd_requests = 0;
  int           tb_errors = 0;
  int           chk_errors;
  int           b_count;
  int           r_count;
  int           cycle_count = 0;

  gfx_ctrl_top gfx_ctrl_top_inst (
    .clk_i (clk_i), .rst_i (rst_i),
    .s_awaddr_i (s_awaddr), .s_awvalid_i (s_awvalid), .s_awready_o (s_awready),
    .s_wdata_i (s_wdata), .s_wstrb_i (s_wstrb), .s_wvalid_i (s_wvalid),
    .s_wready_o (s_wready), .s_bresp_o (s_bresp), .s_bvalid_o (s_bvalid),
    .s_bready_i (s_bready), .s_araddr_i (s_araddr), .s_arvalid_i (s_arvalid),
    .s_arready_o (s_arready), .s_rdata_o (s_rdata), .s_rresp_o (s_rresp),
    .s_rvalid_o (s_rvalid), .s_rready_i (s_rready),
    .draw_params_o (draw_params), .rect_start_o (rect_start),
    .line_start_o (line_start), .draw_done_i (draw_done)
  );

  gfx_ctrl_checker checker_inst (
    .clk_i (clk_i), .rst_i (rst_i),
    .s_awready_i (s_awready), .s_wready_i (s_wready), .s_bresp_i (s_bresp),
    .s_bvalid_i (s_bvalid), .s_bready_i (s_bready), .s_arready_i (s_arready),
    .s_rdata_i (s_rdata), .s_rresp_i (s_rresp), .s_rvalid_i (s_rvalid),
    .s_rready_i (s_rready), .draw_params_i (draw_params),
    .rect_start_i (rect_start), .line_start_i (line_start), .draw_done_i (draw_done),
    .exp_bresp_i (exp_bresp), .exp_rdata_i (exp_rdata), .exp_rmask_i (exp_rmask),
    .exp_params_i (exp_params), .exp_rect_i (exp_rect), .exp_line_i (exp_line),
    .err_count_o (chk_errors), .b_count_o (b_count), .r_count_o (r_count)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // drawing engine model
  initial
  begin
    int delay;
    draw_done = 1'b0;
    forever
    begin
      @(posedge clk_i);
      if (rect_start || line_start)
      begin
        delay = int'($urandom_range(20, 5));
        repeat (delay - 1) @(posedge clk_i);
        #2;
        draw_done = 1'b1;
        @(posedge clk_i);
        #2;
        draw_done = 1'b0;
      end
    end
  end

  function automatic logic [5:0] reg_index(input reg_addr_t addr);
    return addr[GFX_ADDR_W-1:2];
  endfunction

  function automatic logic is_mapped(input reg_addr_t addr);
    return (addr[1:0] == 2'b00) && (addr <= GFX_ALPHA);
  endfunction

  // applied value after a full-word write, triggers already launched
  function automatic void apply_write(input reg_addr_t addr, input reg_word_t data);
    if (is_mapped(addr) && (addr != GFX_STATUS))
    begin
      shadow[reg_index(addr)] = data;
      if (addr == GFX_CONTROL)
      begin
        shadow[reg_index(addr)] = data & ~TRIG_MASK;
      end
    end
  endfunction

  // status is zero once idle with an empty queue
  function automatic reg_word_t gfx_expect_read(input reg_addr_t addr);
    if (!is_mapped(addr) || (addr == GFX_STATUS))
    begin
      return '0;
    end
    return shadow[reg_index(addr)];
  endfunction

  function automatic draw_params_t expect_params();
    draw_params_t p;
    reg_word_t    ctrl;
    reg_word_t    base;
    reg_word_t    alpha;
    ctrl  = gfx_expect_read(GFX_CONTROL);
    base  = gfx_expect_read(GFX_TARGET_BASE);
    alpha = gfx_expect_read(GFX_ALPHA);
    p.target_base  = base[REG_W-1:GFX_BASE_LSB];
    p.size_x       = point_t'(gfx_expect_read(GFX_TARGET_SIZE_X));
    p.size_y       = point_t'(gfx_expect_read(GFX_TARGET_SIZE_Y));
    p.clip_x0      = point_t'(gfx_expect_read(GFX_CLIP_X0));
    p.clip_y0      = point_t'(gfx_expect_read(GFX_CLIP_Y0));
    p.clip_x1      = point_t'(gfx_expect_read(GFX_CLIP_X1));
    p.clip_y1      = point_t'(gfx_expect_read(GFX_CLIP_Y1));
    p.dest_x       = point_t'(gfx_expect_read(GFX_DEST_X));
    p.dest_y       = point_t'(gfx_expect_read(GFX_DEST_Y));
    p.color0       = gfx_expect_read(GFX_COLOR0);
    p.global_alpha = alpha[ALPHA_W-1:0];
    p.color_depth  = ctrl[GFX_CTRL_DEPTH_LSB +: GFX_CTRL_DEPTH_W];
    p.clip_enable  = ctrl[GFX_CTRL_CLIP];
    p.blend_enable = ctrl[GFX_CTRL_BLEND];
    return p;
  endfunction

  task automatic axi_write(input reg_addr_t addr, input reg_word_t data,
                           input axi_strb_t strb);
    int stall;
    stall = use_stalls ? int'($urandom_range(3, 0)) : 0;
    exp_bresp = (strb == AXI_STRB_FULL) ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
    s_awaddr  = addr;
    s_wdata   = data;
    s_wstrb   = strb;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    @(posedge clk_i);
    while (!s_awready) @(posedge clk_i);
    #2;
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    wr_requests = wr_requests + 1;
    repeat (stall)
    begin
      @(posedge clk_i);
      #2;
    end
    s_bready = 1'b1;
    @(posedge clk_i);
    while (!s_bvalid) @(posedge clk_i);
    #2;
    s_bready = 1'b0;
    if (strb == AXI_STRB_FULL)
    begin
      apply_write(addr, data);
    end
  endtask

  task automatic axi_read(input reg_addr_t addr, input reg_word_t exp_data,
                          input reg_word_t exp_mask, output reg_word_t data);
    int stall;
    stall = use_stalls ? int'($urandom_range(3, 0)) : 0;
    exp_rdata = exp_data;
    exp_rmask = exp_mask;
    s_araddr  = addr;
    s_arvalid = 1'b1;
    @(posedge clk_i);
    while (!s_arready) @(posedge clk_i);
    #2;
    s_arvalid = 1'b0;
    rd_requests = rd_requests + 1;
    repeat (stall)
    begin
      @(posedge clk_i);
      #2;
    end
    s_rready = 1'b1;
    @(posedge clk_i);
    while (!s_rvalid) @(posedge clk_i);
    data = s_rdata;
    #2;
    s_rready = 1'b0;
  endtask

  task automatic read_check(input reg_addr_t addr);
    reg_word_t data;
    axi_read(addr, gfx_expect_read(addr), '1, data);
  endtask

  task automatic read_all();
    for (int i = 0; i <= 12; i++)
    begin
      read_check(reg_addr_t'(4 * i));
    end
  endtask

  // poll status until idle with an empty queue
  task automatic wait_idle();
    reg_word_t status;
    status = '1;
    while (status != '0)
    begin
      axi_read(GFX_STATUS, '0, '0, status);
    end
  endtask

  task automatic run_draw(input logic use_line);
    reg_word_t ctrl;
    reg_word_t status;
    reg_addr_t addr;
    for (int i = 2; i <= 12; i++)
    begin
      axi_write(reg_addr_t'(4 * i), $urandom(), AXI_STRB_FULL);
    end
    wait_idle();
    ctrl = $urandom() & ~TRIG_MASK;
    ctrl[use_line ? GFX_CTRL_LINE : GFX_CTRL_RECT] = 1'b1;
    // the engine sees the registers as they stand at the trigger
    apply_write(GFX_CONTROL, ctrl);
    exp_params = expect_params();
    exp_rect   = ~use_line;
    exp_line   = use_line;
    axi_write(GFX_CONTROL, ctrl, AXI_STRB_FULL);
    axi_read(GFX_STATUS, 32'h1 << GFX_STAT_BUSY, 32'h1 << GFX_STAT_BUSY, status);
    for (int i = 0; i < 4; i++)
    begin
      addr = reg_addr_t'(8 + 4 * $urandom_range(10, 0));
      axi_write(addr, $urandom(), AXI_STRB_FULL);
    end
    wait_idle();
    exp_rect = 1'b0;
    exp_line = 1'b0;
    read_all();
  endtask

  task automatic print_counts();
    $display("error count: checker %0d, testbench %0d", chk_errors, tb_errors);
  endtask

  initial
  begin
    while (cycle_count < CYCLE_LIMIT)
    begin
      @(posedge clk_i);
      cycle_count = cycle_count + 1;
    end
    $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    print_counts();
    $display("Finished with errors");
    $finish;
  end

  initial
  begin
    reg_word_t data;
    reg_addr_t addr;
    void'($urandom(77615));
    rst_i      = 1'b1;
    s_awaddr   = '0;
    s_awvalid  = 1'b0;
    s_wdata    = '0;
    s_wstrb    = '0;
    s_wvalid   = 1'b0;
    s_bready   = 1'b0;
    s_araddr   = '0;
    s_arvalid  = 1'b0;
    s_rready   = 1'b0;
    exp_bresp  = AXI_RESP_OKAY;
    exp_rdata  = '0;
    exp_rmask  = '0;
    exp_params = '0;
    exp_rect   = 1'b0;
    exp_line   = 1'b0;
    use_stalls = 1'b0;
    for (int i = 0; i < 64; i++)
    begin
      shadow[i] = '0;
    end
    shadow[reg_index(GFX_ALPHA)] = GFX_ALPHA_RESET;
    repeat (2) @(posedge clk_i);
    #2;
    rst_i = 1'b0;

    // reset values, then unmapped words
    read_all();
    read_check(8'h34);
    read_check(8'hFC);

    // full-word writes to every register, status included
    for (int i = 0; i <= 12; i++)
    begin
      addr = reg_addr_t'(4 * i);
      data = $urandom();
      if (addr == GFX_CONTROL)
      begin
        data = data & ~TRIG_MASK;
      end
      axi_write(addr, data, AXI_STRB_FULL);
    end
    wait_idle();
    read_all();

    // partial strobes, one of them carrying a trigger
    axi_write(GFX_COLOR0, $urandom(), 4'b0111);
    axi_write(GFX_DEST_X, $urandom(), 4'b1000);
    axi_write(GFX_CONTROL, $urandom() | TRIG_MASK, 4'b0001);
    wait_idle();
    read_all();

    run_draw(1'b0);
    use_stalls = 1'b1;
    run_draw(1'b1);

    if ((wr_requests != b_count) || (rd_requests != r_count))
    begin
      $display("response count does not match: %0d writes got %0d B, %0d reads got %0d R",
               wr_requests, b_count, rd_requests, r_count);
      tb_errors = tb_errors + 1;
    end
    print_counts();
    if ((chk_errors + tb_errors) == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
src/gfx_reg_pkg.sv
src/gfx_types_pkg.sv
src/gfx_axil_slave.sv
src/gfx_cmd_fifo.sv
src/gfx_cmd_executor.sv
src/gfx_ctrl_top.sv
sim/gfx_ctrl_checker.sv
sim/tb_gfx_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       ?= tb_gfx_ctrl
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Finished with no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
